// File: filelist.f
common/decode_pkg.sv
hdl/pipe_reg.sv
decode/imm_gen.sv
decode/warp_ctrl_decode.sv
decode/instr_decoder.sv
decode/decode_stage.sv
tb/decode_checker.sv
tb/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module decode_tb -f filelist.f \
    -o sim_decode > sim.log 2>&1 &&
    ./obj_dir/sim_decode >> sim.log 2>&1
grep -q "Result: FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"

// File: tb/decode_tb.sv
bind decode_stage decode_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .decode_valid (decode_valid),
    .decode_pkt   (decode_pkt),
    .decode_ready (decode_ready),
    .wstall_valid (wstall_valid),
    .wstall       (wstall),
    .join_valid   (join_valid)
);

module decode_tb;

    typedef struct packed {
        logic [31:0]             instr;
        logic [1:0]              wid;
        logic [3:0]              tmask;
        logic [31:0]             pc;
        decode_pkg::decode_pkt_t exp;
        logic                    stalled;
        logic                    is_join;
    } row_t;

    logic                    clk;
    logic                    reset;
    logic                    fetch_valid;
    decode_pkg::fetch_rsp_t  fetch_rsp;
    logic                    fetch_ready;
    logic                    decode_valid;
    decode_pkg::decode_pkt_t decode_pkt;
    logic                    decode_ready;
    logic                    wstall_valid;
    decode_pkg::wstall_t     wstall;
    logic                    join_valid;
    logic [1:0]              join_wid;

    row_t        rows[$];
    int          in_idx;
    int          out_idx;
    logic [31:0] lcg_state = 32'h3f8d_337f;

    decode_stage DUT (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_rsp    (fetch_rsp),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_pkt   (decode_pkt),
        .decode_ready (decode_ready),
        .wstall_valid (wstall_valid),
        .wstall       (wstall),
        .join_valid   (join_valid),
        .join_wid     (join_wid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
        assert (got === expv)
        else fail_run($sformatf("FAILED %s got %h expected %h", name, got, expv));
    endtask

    // flags = {wb, use_pc, use_imm, stalled, join}
    task automatic add_row(input logic [31:0] instr, input decode_pkg::ex_type_e ex,
                           input logic [3:0] op, input logic [2:0] md, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm,
                           input logic [4:0] flags);
        row_t r;
        int   n;
        n = rows.size();
        r.instr = instr;
        r.wid   = 2'(n);
        r.tmask = 4'(n * 3 + 1);
        r.pc    = 32'h0000_1000 + 32'(n * 4);
        r.exp.wid     = r.wid;
        r.exp.tmask   = r.tmask;
        r.exp.pc      = r.pc;
        r.exp.ex_type = ex;
        r.exp.op_type = op;
        r.exp.op_mod  = md;
        r.exp.wb      = flags[4];
        r.exp.rd      = rd;
        r.exp.rs1     = rs1;
        r.exp.rs2     = rs2;
        r.exp.imm     = imm;
        r.exp.use_pc  = flags[3];
        r.exp.use_imm = flags[2];
        r.stalled     = flags[1];
        r.is_join     = flags[0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(32'hFFB10093, decode_pkg::EX_ALU, decode_pkg::ALU_ADD, 3'd0,
                5'd1, 5'd2, 5'd0, 32'hFFFF_FFFB, 5'b10100); // addi x1, x2, -5
        add_row(32'h40725193, decode_pkg::EX_ALU, decode_pkg::ALU_SRA, 3'd0,
                5'd3, 5'd4, 5'd0, 32'h0000_0007, 5'b10100);
        add_row(32'h409403B3, decode_pkg::EX_ALU, decode_pkg::ALU_SUB, 3'd0,
                5'd7, 5'd8, 5'd9, 32'h0, 5'b10000);
        add_row(32'h00C5F533, decode_pkg::EX_ALU, decode_pkg::ALU_AND, 3'd0,
                5'd10, 5'd11, 5'd12, 32'h0, 5'b10000);
        add_row(32'h00128013, decode_pkg::EX_ALU, decode_pkg::ALU_ADD, 3'd0,
                5'd0, 5'd5, 5'd0, 32'h1, 5'b00100); // Writes x0
        add_row(32'h123456B7, decode_pkg::EX_ALU, decode_pkg::ALU_LUI, 3'd0,
                5'd13, 5'd0, 5'd0, 32'h1234_5000, 5'b10100);
        add_row(32'hFFFFF717, decode_pkg::EX_ALU, decode_pkg::ALU_AUIPC, 3'd0,
                5'd14, 5'd0, 5'd0, 32'hFFFF_F000, 5'b11100);
        add_row(32'hFF9FF0EF, decode_pkg::EX_ALU, decode_pkg::BR_JAL, 3'd1,
                5'd1, 5'd0, 5'd0, 32'hFFFF_FFF8, 5'b11110); // jal x1, -8
        add_row(32'h00008067, decode_pkg::EX_ALU, decode_pkg::BR_JALR, 3'd1,
                5'd0, 5'd1, 5'd0, 32'h0, 5'b00110);
        add_row(32'h00208863, decode_pkg::EX_ALU, decode_pkg::BR_EQ, 3'd1,
                5'd0, 5'd1, 5'd2, 32'h10, 5'b01110);
        add_row(32'hFE419EE3, decode_pkg::EX_ALU, decode_pkg::BR_NE, 3'd1,
                5'd0, 5'd3, 5'd4, 32'hFFFF_FFFC, 5'b01110);
        add_row(32'h0062C463, decode_pkg::EX_ALU, decode_pkg::BR_LT, 3'd1,
                5'd0, 5'd5, 5'd6, 32'h8, 5'b01110);
        add_row(32'h0062D463, decode_pkg::EX_ALU, decode_pkg::BR_GE, 3'd1,
                5'd0, 5'd5, 5'd6, 32'h8, 5'b01110);
        add_row(32'h0062E463, decode_pkg::EX_ALU, decode_pkg::BR_LTU, 3'd1,
                5'd0, 5'd5, 5'd6, 32'h8, 5'b01110);
        add_row(32'h0062F463, decode_pkg::EX_ALU, decode_pkg::BR_GEU, 3'd1,
                5'd0, 5'd5, 5'd6, 32'h8, 5'b01110);
        add_row(32'hFFC82783, decode_pkg::EX_LSU, decode_pkg::LSU_LW, 3'd0,
                5'd15, 5'd16, 5'd0, 32'hFFFF_FFFC, 5'b10000);
        add_row(32'h01192A23, decode_pkg::EX_LSU, 4'hA, 3'd0,
                5'd0, 5'd18, 5'd17, 32'h14, 5'b00000); // sw x17, 20(x18)
        add_row(32'h0FF0000F, decode_pkg::EX_LSU, 4'h0, 3'd1,
                5'd0, 5'd0, 5'd0, 32'h0, 5'b00000);
        add_row(32'h300A19F3, decode_pkg::EX_CSR, 4'h1, 3'd0,
                5'd19, 5'd20, 5'd0, 32'h300, 5'b10000);
        add_row(32'h3412EAF3, decode_pkg::EX_CSR, 4'h2, 3'd0,
                5'd21, 5'd0, 5'd0, 32'h5341, 5'b10100); // csrrsi, zimm 5
        add_row(32'h00000073, decode_pkg::EX_ALU, decode_pkg::BR_ECALL, 3'd1,
                5'd0, 5'd0, 5'd0, 32'h4, 5'b01110);
        add_row(32'h30200073, decode_pkg::EX_ALU, decode_pkg::BR_MRET, 3'd1,
                5'd0, 5'd0, 5'd0, 32'h4, 5'b01110);
        add_row(32'h0000806B, decode_pkg::EX_GPU, decode_pkg::GPU_TMC, 3'd0,
                5'd0, 5'd1, 5'd0, 32'h0, 5'b00010);
        add_row(32'h0011006B, decode_pkg::EX_GPU, decode_pkg::GPU_PRED, 3'd0,
                5'd0, 5'd2, 5'd0, 32'h0, 5'b00010);
        add_row(32'h0041906B, decode_pkg::EX_GPU, decode_pkg::GPU_WSPAWN, 3'd0,
                5'd0, 5'd3, 5'd4, 32'h0, 5'b00000);
        add_row(32'h0002A06B, decode_pkg::EX_GPU, decode_pkg::GPU_SPLIT, 3'd0,
                5'd0, 5'd5, 5'd0, 32'h0, 5'b00010);
        add_row(32'h0000306B, decode_pkg::EX_GPU, decode_pkg::GPU_JOIN, 3'd0,
                5'd0, 5'd0, 5'd0, 32'h0, 5'b00001);
        add_row(32'h0073406B, decode_pkg::EX_GPU, decode_pkg::GPU_BAR, 3'd0,
                5'd0, 5'd6, 5'd7, 32'h0, 5'b00010);
        add_row(32'h0004606B, decode_pkg::EX_LSU, decode_pkg::LSU_LW, 3'd2,
                5'd0, 5'd8, 5'd0, 32'h0, 5'b00000);
        add_row(32'hFFFFFFFF, decode_pkg::EX_ALU, 4'h0, 3'd0,
                5'd0, 5'd0, 5'd0, 32'h0, 5'b00000); // Undefined opcode
    endtask

    task automatic compare_packet(input row_t r);
        check_val("decode_pkt.wid", 32'(decode_pkt.wid), 32'(r.exp.wid));
        check_val("decode_pkt.tmask", 32'(decode_pkt.tmask), 32'(r.exp.tmask));
        check_val("decode_pkt.pc", decode_pkt.pc, r.exp.pc);
        check_val("decode_pkt.ex_type", 32'(decode_pkt.ex_type), 32'(r.exp.ex_type));
        check_val("decode_pkt.op_type", 32'(decode_pkt.op_type), 32'(r.exp.op_type));
        check_val("decode_pkt.op_mod", 32'(decode_pkt.op_mod), 32'(r.exp.op_mod));
        check_val("decode_pkt.wb", 32'(decode_pkt.wb), 32'(r.exp.wb));
        check_val("decode_pkt.rd", 32'(decode_pkt.rd), 32'(r.exp.rd));
        check_val("decode_pkt.rs1", 32'(decode_pkt.rs1), 32'(r.exp.rs1));
        check_val("decode_pkt.rs2", 32'(decode_pkt.rs2), 32'(r.exp.rs2));
        check_val("decode_pkt.imm", decode_pkt.imm, r.exp.imm);
        check_val("decode_pkt.use_pc", 32'(decode_pkt.use_pc), 32'(r.exp.use_pc));
        check_val("decode_pkt.use_imm", 32'(decode_pkt.use_imm), 32'(r.exp.use_imm));
    endtask

    task automatic check_scheduler(input row_t r);
        check_val("wstall_valid", 32'(wstall_valid), 32'h1);
        check_val("wstall.wid", 32'(wstall.wid), 32'(r.wid));
        check_val("wstall.stalled", 32'(wstall.stalled), 32'(r.stalled));
        check_val("join_valid", 32'(join_valid), 32'(r.is_join));
        if (r.is_join)
            check_val("join_wid", 32'(join_wid), 32'(r.wid));
    endtask

    // Random back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        #2;
        lcg_state    = lcg_next(lcg_state);
        decode_ready = (lcg_state[17:16] != 2'b00);
    end

    // Sampled mid-cycle, inputs only move just after the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            // Register holds one packet between its fetch and issue transfers
            check_val("decode_valid", 32'(decode_valid), 32'(in_idx != out_idx));
            check_val("fetch_ready", 32'(fetch_ready),
                      32'(in_idx == out_idx || decode_ready));
            if (fetch_valid && fetch_ready) begin
                check_scheduler(rows[in_idx]);
                in_idx++;
            end else begin
                check_val("wstall_valid", 32'(wstall_valid), 32'h0);
                check_val("join_valid", 32'(join_valid), 32'h0);
            end
            if (decode_valid && decode_ready) begin
                compare_packet(rows[out_idx]);
                out_idx++;
            end
        end
    end

    initial begin
        #1;
        #(40 * (20 * rows.size() + 100));
        fail_run("Timeout: not every instruction reached the issue side in time");
    end

    initial begin
        logic accepted;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_rsp    = '0;
        decode_ready = 1'b0;
        in_idx       = 0;
        out_idx      = 0;
        build_table();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (rows[i]) begin
            fetch_valid     = 1'b1;
            fetch_rsp.wid   = rows[i].wid;
            fetch_rsp.tmask = rows[i].tmask;
            fetch_rsp.pc    = rows[i].pc;
            fetch_rsp.instr = rows[i].instr;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = fetch_ready;
                @(posedge clk);
                #2;
            end
        end
        fetch_valid = 1'b0;
        wait (out_idx == rows.size());
        // Nothing else may leave the register
        repeat (2) @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tb/decode_checker.sv
module decode_checker (
    input logic                    clk,
    input logic                    reset,
    input logic                    decode_valid,
    input decode_pkg::decode_pkt_t decode_pkt,
    input logic                    decode_ready,
    input logic                    wstall_valid,
    input decode_pkg::wstall_t     wstall,
    input logic                    join_valid
);

    // Output register empties on reset
    assert property (@(posedge clk) reset |=> !decode_valid)
        else $error("decode_valid high after a reset cycle");

    // Packet held under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        decode_valid && !decode_ready |=> decode_valid && $stable(decode_pkt))
        else $error("Issue packet changed or dropped while stalled");

    // A join never holds the warp
    assert property (@(posedge clk) disable iff (reset)
        join_valid |-> wstall_valid && !wstall.stalled)
        else $error("join_valid without an unstalled wstall_valid");

    // No write-back to x0 or from warp control
    assert property (@(posedge clk) disable iff (reset)
        decode_valid && decode_pkt.wb |->
            decode_pkt.rd != '0 && decode_pkt.ex_type != decode_pkg::EX_GPU)
        else $error("Write-back flagged with rd of zero or on a warp-control op");

endmodule

// File: decode/decode_stage.sv
module decode_stage (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          fetch_valid,
    input  decode_pkg::fetch_rsp_t        fetch_rsp,
    output logic                          fetch_ready,

    output logic                          decode_valid,
    output decode_pkg::decode_pkt_t       decode_pkt,
    input  logic                          decode_ready,

    output logic                          wstall_valid,
    output decode_pkg::wstall_t           wstall,

    output logic                          join_valid,
    output logic [decode_pkg::WID_BITS-1:0] join_wid
);

    decode_pkg::decode_pkt_t dec_pkt;
    logic                    dec_wstall;
    logic                    dec_join;
    logic                    reg_ready;
    logic                    fetch_fire;

    instr_decoder u_decoder (
        .fetch_rsp  (fetch_rsp),
        .pkt        (dec_pkt),
        .is_wstall  (dec_wstall),
        .is_join    (dec_join)
    );

    // Registers the packet toward issue
    pipe_reg u_out_reg (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (fetch_valid),
        .in_data    (dec_pkt),
        .in_ready   (reg_ready),
        .out_valid  (decode_valid),
        .out_data   (decode_pkt),
        .out_ready  (decode_ready)
    );

    assign fetch_ready = reg_ready;
    assign fetch_fire  = fetch_valid && reg_ready;

    // Scheduler learns about the warp in the accept cycle
    assign wstall_valid   = fetch_fire;
    assign wstall.wid     = fetch_rsp.wid;
    assign wstall.stalled = dec_wstall;

    assign join_valid = fetch_fire && dec_join;
    assign join_wid   = fetch_rsp.wid;

endmodule

// File: decode/instr_decoder.sv
module instr_decoder (
    input  decode_pkg::fetch_rsp_t  fetch_rsp,
    output decode_pkg::decode_pkt_t pkt,
    output logic                    is_wstall,
    output logic                    is_join
);

    logic [decode_pkg::XLEN-1:0]    instr;
    logic [6:0]                     opcode;
    logic [2:0]                     func3;
    logic [6:0]                     func7;
    logic [11:0]                    u_12;
    logic [decode_pkg::NR_BITS-1:0] rd;
    logic [decode_pkg::NR_BITS-1:0] rs1;
    logic [decode_pkg::NR_BITS-1:0] rs2;

    decode_pkg::ex_type_e            ex_type;
    logic [decode_pkg::OP_BITS-1:0]  op_type;
    logic [decode_pkg::MOD_BITS-1:0] op_mod;
    logic [decode_pkg::NR_BITS-1:0]  rd_r;
    logic [decode_pkg::NR_BITS-1:0]  rs1_r;
    logic [decode_pkg::NR_BITS-1:0]  rs2_r;
    logic                            use_rd;
    logic                            use_pc;
    logic                            use_imm;
    logic [decode_pkg::XLEN-1:0]     imm;

    decode_pkg::ex_type_e            gpu_ex_type;
    logic [decode_pkg::OP_BITS-1:0]  gpu_op_type;
    logic [decode_pkg::MOD_BITS-1:0] gpu_op_mod;
    logic                            gpu_use_rs1;
    logic                            gpu_use_rs2;
    logic                            gpu_wstall;
    logic                            gpu_join;

    assign instr  = fetch_rsp.instr;
    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign u_12   = instr[31:20];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    imm_gen u_imm_gen (
        .instr  (instr),
        .imm    (imm)
    );

    warp_ctrl_decode u_warp_ctrl (
        .instr      (instr),
        .ex_type    (gpu_ex_type),
        .op_type    (gpu_op_type),
        .op_mod     (gpu_op_mod),
        .use_rs1    (gpu_use_rs1),
        .use_rs2    (gpu_use_rs2),
        .is_wstall  (gpu_wstall),
        .is_join    (gpu_join)
    );

    always_comb begin
        ex_type   = decode_pkg::EX_ALU;
        op_type   = '0;
        op_mod    = '0;
        rd_r      = '0;
        rs1_r     = '0;
        rs2_r     = '0;
        use_rd    = 1'b0;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        is_wstall = 1'b0;
        is_join   = 1'b0;

        case (opcode)
            decode_pkg::OPC_I, decode_pkg::OPC_R: begin
                case (func3)
                    3'h0: begin
                        // SUB only exists in the register form
                        if (opcode == decode_pkg::OPC_R && func7[5])
                            op_type = decode_pkg::ALU_SUB;
                        else
                            op_type = decode_pkg::ALU_ADD;
                    end
                    3'h1: op_type = decode_pkg::ALU_SLL;
                    3'h2: op_type = decode_pkg::ALU_SLT;
                    3'h3: op_type = decode_pkg::ALU_SLTU;
                    3'h4: op_type = decode_pkg::ALU_XOR;
                    3'h5: op_type = func7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                    3'h6: op_type = decode_pkg::ALU_OR;
                    default: op_type = decode_pkg::ALU_AND;
                endcase
                use_rd = 1'b1;
                rd_r   = rd;
                rs1_r  = rs1;
                if (opcode == decode_pkg::OPC_I)
                    use_imm = 1'b1;
                else
                    rs2_r = rs2;
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                op_type = (opcode == decode_pkg::OPC_LUI) ? decode_pkg::ALU_LUI
                                                          : decode_pkg::ALU_AUIPC;
                use_rd  = 1'b1;
                rd_r    = rd;
                use_imm = 1'b1;
                use_pc  = (opcode == decode_pkg::OPC_AUIPC);
            end
            decode_pkg::OPC_JAL: begin
                op_type   = decode_pkg::BR_JAL;
                op_mod    = decode_pkg::MOD_BRANCH;
                use_rd    = 1'b1;
                rd_r      = rd;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                is_wstall = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                op_type   = decode_pkg::BR_JALR;
                op_mod    = decode_pkg::MOD_BRANCH;
                use_rd    = 1'b1;
                rd_r      = rd;
                rs1_r     = rs1;
                use_imm   = 1'b1;
                is_wstall = 1'b1;
            end
            decode_pkg::OPC_B: begin
                case (func3)
                    3'h1: op_type = decode_pkg::BR_NE;
                    3'h4: op_type = decode_pkg::BR_LT;
                    3'h5: op_type = decode_pkg::BR_GE;
                    3'h6: op_type = decode_pkg::BR_LTU;
                    3'h7: op_type = decode_pkg::BR_GEU;
                    default: op_type = decode_pkg::BR_EQ;
                endcase
                op_mod    = decode_pkg::MOD_BRANCH;
                rs1_r     = rs1;
                rs2_r     = rs2;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                is_wstall = 1'b1;
            end
            decode_pkg::OPC_L: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = {1'b0, func3};
                use_rd  = 1'b1;
                rd_r    = rd;
                rs1_r   = rs1;
            end
            decode_pkg::OPC_S: begin
                ex_type = decode_pkg::EX_LSU;
                op_type = {1'b1, func3}; // Bit 3 marks a store
                rs1_r   = rs1;
                rs2_r   = rs2;
            end
            decode_pkg::OPC_FENCE: begin
                ex_type = decode_pkg::EX_LSU;
                op_mod  = decode_pkg::MOD_FENCE;
            end
            decode_pkg::OPC_SYS: begin
                if (func3[1:0] != 2'b00) begin
                    ex_type = decode_pkg::EX_CSR;
                    op_type = {2'b00, func3[1:0]};
                    use_rd  = 1'b1;
                    rd_r    = rd;
                    use_imm = func3[2];
                    if (!func3[2])
                        rs1_r = rs1; // Immediate form carries rs1 in imm
                end else begin
                    case (u_12)
                        12'h001: op_type = decode_pkg::BR_EBREAK;
                        12'h302: op_type = decode_pkg::BR_MRET;
                        12'h102: op_type = decode_pkg::BR_SRET;
                        12'h7B2: op_type = decode_pkg::BR_DRET;
                        default: op_type = decode_pkg::BR_ECALL;
                    endcase
                    op_mod    = decode_pkg::MOD_BRANCH;
                    use_rd    = 1'b1;
                    rd_r      = rd;
                    use_imm   = 1'b1;
                    use_pc    = 1'b1;
                    is_wstall = 1'b1;
                end
            end
            decode_pkg::OPC_GPU: begin
                ex_type   = gpu_ex_type;
                op_type   = gpu_op_type;
                op_mod    = gpu_op_mod;
                rs1_r     = gpu_use_rs1 ? rs1 : '0;
                rs2_r     = gpu_use_rs2 ? rs2 : '0;
                is_wstall = gpu_wstall;
                is_join   = gpu_join;
            end
            default: ;
        endcase
    end

    assign pkt.wid     = fetch_rsp.wid;
    assign pkt.tmask   = fetch_rsp.tmask;
    assign pkt.pc      = fetch_rsp.pc;
    assign pkt.ex_type = ex_type;
    assign pkt.op_type = op_type;
    assign pkt.op_mod  = op_mod;
    assign pkt.wb      = use_rd && (rd_r != '0); // x0 is never written
    assign pkt.rd      = rd_r;
    assign pkt.rs1     = rs1_r;
    assign pkt.rs2     = rs2_r;
    assign pkt.imm     = imm;
    assign pkt.use_pc  = use_pc;
    assign pkt.use_imm = use_imm;

endmodule

// File: decode/warp_ctrl_decode.sv
module warp_ctrl_decode (
    input  logic [decode_pkg::XLEN-1:0]     instr,
    output decode_pkg::ex_type_e            ex_type,
    output logic [decode_pkg::OP_BITS-1:0]  op_type,
    output logic [decode_pkg::MOD_BITS-1:0] op_mod,
    output logic                            use_rs1,
    output logic                            use_rs2,
    output logic                            is_wstall,
    output logic                            is_join
);

    logic [2:0] func3;
    logic       rs2_lsb;

    assign func3   = instr[14:12];
    assign rs2_lsb = instr[20];

    always_comb begin
        ex_type   = decode_pkg::EX_GPU;
        op_type   = '0;
        op_mod    = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;
        is_join   = 1'b0;

        case (func3)
            3'h0: begin
                op_type   = rs2_lsb ? decode_pkg::GPU_PRED : decode_pkg::GPU_TMC;
                use_rs1   = 1'b1;
                is_wstall = 1'b1;
            end
            3'h1: begin
                op_type = decode_pkg::GPU_WSPAWN;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            3'h2: begin
                op_type   = decode_pkg::GPU_SPLIT;
                use_rs1   = 1'b1;
                is_wstall = 1'b1;
            end
            3'h3: begin
                op_type = decode_pkg::GPU_JOIN;
                is_join = 1'b1;
            end
            3'h4: begin
                op_type   = decode_pkg::GPU_BAR;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_wstall = 1'b1;
            end
            3'h6: begin
                // Routed to the LSU as a word load
                ex_type = decode_pkg::EX_LSU;
                op_type = decode_pkg::LSU_LW;
                op_mod  = decode_pkg::MOD_GPU_MEM;
                use_rs1 = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: decode/imm_gen.sv
module imm_gen (
    input  logic [decode_pkg::XLEN-1:0] instr,
    output logic [decode_pkg::XLEN-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] func3;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];

    always_comb begin
        imm = '0;
        case (opcode)
            decode_pkg::OPC_I: begin
                if (func3[1:0] == 2'b01)
                    imm = {27'b0, instr[24:20]}; // shamt
                else
                    imm = {{20{instr[31]}}, instr[31:20]};
            end
            decode_pkg::OPC_L, decode_pkg::OPC_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            decode_pkg::OPC_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            decode_pkg::OPC_B:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            decode_pkg::OPC_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC:
                imm = {instr[31:12], 12'b0};
            decode_pkg::OPC_SYS: begin
                if (func3[1:0] != 2'b00) begin
                    imm[decode_pkg::CSR_ADDR_BITS-1:0] = instr[31:20]; // CSR address
                    if (func3[2])
                        imm[decode_pkg::CSR_ADDR_BITS +: decode_pkg::NR_BITS] = instr[19:15];
                end else begin
                    imm = 32'd4; // Return address offset
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/pipe_reg.sv
module pipe_reg (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_valid,
    input  decode_pkg::decode_pkt_t in_data,
    output logic                    in_ready,

    output logic                    out_valid,
    output decode_pkg::decode_pkt_t out_data,
    input  logic                    out_ready
);

    logic                    valid_q;
    decode_pkg::decode_pkt_t data_q;

    // Empty, or draining this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// File: common/decode_pkg.sv
package decode_pkg;

    localparam int NUM_WARPS     = 4;
    localparam int WID_BITS      = $clog2(NUM_WARPS);
    localparam int NUM_THREADS   = 4;
    localparam int NR_BITS       = 5;
    localparam int XLEN          = 32;
    localparam int CSR_ADDR_BITS = 12;
    localparam int OP_BITS       = 4;
    localparam int MOD_BITS      = 3;

    // Major opcodes
    localparam logic [6:0] OPC_I     = 7'h13;
    localparam logic [6:0] OPC_R     = 7'h33;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_JAL   = 7'h6F;
    localparam logic [6:0] OPC_JALR  = 7'h67;
    localparam logic [6:0] OPC_B     = 7'h63;
    localparam logic [6:0] OPC_L     = 7'h03;
    localparam logic [6:0] OPC_S     = 7'h23;
    localparam logic [6:0] OPC_FENCE = 7'h0F;
    localparam logic [6:0] OPC_SYS   = 7'h73;
    localparam logic [6:0] OPC_GPU   = 7'h6B; // Warp control group

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_CSR = 2'd2,
        EX_GPU = 2'd3
    } ex_type_e;

    localparam logic [OP_BITS-1:0] ALU_ADD   = 4'd0;
    localparam logic [OP_BITS-1:0] ALU_SUB   = 4'd1;
    localparam logic [OP_BITS-1:0] ALU_SLL   = 4'd2;
    localparam logic [OP_BITS-1:0] ALU_SLT   = 4'd3;
    localparam logic [OP_BITS-1:0] ALU_SLTU  = 4'd4;
    localparam logic [OP_BITS-1:0] ALU_XOR   = 4'd5;
    localparam logic [OP_BITS-1:0] ALU_SRL   = 4'd6;
    localparam logic [OP_BITS-1:0] ALU_SRA   = 4'd7;
    localparam logic [OP_BITS-1:0] ALU_OR    = 4'd8;
    localparam logic [OP_BITS-1:0] ALU_AND   = 4'd9;
    localparam logic [OP_BITS-1:0] ALU_LUI   = 4'd10;
    localparam logic [OP_BITS-1:0] ALU_AUIPC = 4'd11;

    // Branch unit ops, carried with op_mod MOD_BRANCH
    localparam logic [OP_BITS-1:0] BR_EQ     = 4'd0;
    localparam logic [OP_BITS-1:0] BR_NE     = 4'd1;
    localparam logic [OP_BITS-1:0] BR_LT     = 4'd2;
    localparam logic [OP_BITS-1:0] BR_GE     = 4'd3;
    localparam logic [OP_BITS-1:0] BR_LTU    = 4'd4;
    localparam logic [OP_BITS-1:0] BR_GEU    = 4'd5;
    localparam logic [OP_BITS-1:0] BR_JAL    = 4'd6;
    localparam logic [OP_BITS-1:0] BR_JALR   = 4'd7;
    localparam logic [OP_BITS-1:0] BR_ECALL  = 4'd8;
    localparam logic [OP_BITS-1:0] BR_EBREAK = 4'd9;
    localparam logic [OP_BITS-1:0] BR_MRET   = 4'd10;
    localparam logic [OP_BITS-1:0] BR_SRET   = 4'd11;
    localparam logic [OP_BITS-1:0] BR_DRET   = 4'd12;

    localparam logic [OP_BITS-1:0] GPU_TMC    = 4'd0;
    localparam logic [OP_BITS-1:0] GPU_WSPAWN = 4'd1;
    localparam logic [OP_BITS-1:0] GPU_SPLIT  = 4'd2;
    localparam logic [OP_BITS-1:0] GPU_JOIN   = 4'd3;
    localparam logic [OP_BITS-1:0] GPU_BAR    = 4'd4;
    localparam logic [OP_BITS-1:0] GPU_PRED   = 4'd5;

    localparam logic [OP_BITS-1:0] LSU_LW = 4'd2;

    localparam logic [MOD_BITS-1:0] MOD_BRANCH  = 3'd1;
    localparam logic [MOD_BITS-1:0] MOD_FENCE   = 3'd1;
    localparam logic [MOD_BITS-1:0] MOD_GPU_MEM = 3'd2; // Warp control through the LSU

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        instr;
    } fetch_rsp_t;

    typedef struct packed {
        logic [WID_BITS-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        ex_type_e               ex_type;
        logic [OP_BITS-1:0]     op_type;
        logic [MOD_BITS-1:0]    op_mod;
        logic                   wb;
        logic [NR_BITS-1:0]     rd;
        logic [NR_BITS-1:0]     rs1;
        logic [NR_BITS-1:0]     rs2;
        logic [XLEN-1:0]        imm;
        logic                   use_pc;
        logic                   use_imm;
    } decode_pkt_t;

    typedef struct packed {
        logic [WID_BITS-1:0] wid;
        logic                stalled;
    } wstall_t;

endpackage
